//--- hdl/cache_params.svh
// Cache geometry macros: address, tag, index and offset widths, words per line and way count.
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

//////////////////////////////
// Address split.
//////////////////////////////
`define CACHE_ADDR_W 16      // Byte address width of the 16-bit machine.
`define CACHE_TAG_W 6        // Upper address bits kept in each tag entry.
`define CACHE_INDEX_W 6      // Selects one of 64 sets.
`define CACHE_OFFSET_W 4     // Byte offset within a 16-byte line.

//////////////////////////////
// Line and set shape.
//////////////////////////////
`define CACHE_LINE_WORDS 8   // 16-bit words per line.
`define CACHE_WAYS 2         // Two-way set associative.

`endif

//--- hdl/cache_pkg.sv
// Cache package: data word, split address struct and tag entry struct.
`include "cache_params.svh"

package cache_pkg;

  // One machine word as it travels on both data buses.
  typedef logic [15:0] word_t;

  // Processor byte address as the cache sees it.
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]    tag;     // Compared against the stored tag.
    logic [`CACHE_INDEX_W-1:0]  index;   // Picks the set.
    logic [`CACHE_OFFSET_W-1:0] offset;  // Byte within the line, bit 0 unused for words.
  } cache_addr_t;

  // One line's bookkeeping in the tag array.
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0] tag;  // Tag of the line held in this way.
    logic                    valid; // Line holds fetched data.
    logic                    lru;   // Set when this way is the one to evict next.
  } tag_entry_t;

endpackage

//--- hdl/cache_lookup_if.sv
// Lookup-to-fill interface with the lookup and fill modports.
`timescale 1ns/100ps

interface cache_lookup_if;

  // Lookup stage side.
  logic                   valid;     // A request sits in the lookup stage.
  cache_pkg::cache_addr_t addr;      // Captured request address.
  logic                   hit;       // One of the ways matched.
  logic                   hit_way;   // Matching way, meaningful when hit is set.
  logic                   evict_way; // LRU way of the set.

  // Fill controller side.
  logic                   done;      // Pulse that frees the lookup stage.
  logic                   tag_we;    // Pulse that installs the new tag in evict_way.
  logic                   lru_we;    // Pulse that updates the set's LRU bits.
  logic                   lru_way;   // Way that becomes most recently used.

  modport lookup (
    output valid, addr, hit, hit_way, evict_way,
    input  done, tag_we, lru_we, lru_way
  );

  modport fill (
    input  valid, addr, hit, hit_way, evict_way,
    output done, tag_we, lru_we, lru_way
  );

endinterface

//--- hdl/cache_tag_lookup.sv
// Lookup stage: request capture, tag and LRU arrays, tag compare and data read address.
`timescale 1ns/100ps
`include "cache_params.svh"

module cache_tag_lookup (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cpu_req,
  input  cache_pkg::cache_addr_t cpu_addr,
  cache_lookup_if.lookup         look,
  output logic                   rd_way,
  output logic [`CACHE_INDEX_W+$clog2(`CACHE_LINE_WORDS)-1:0] rd_addr
);

  localparam int SETS = 1 << `CACHE_INDEX_W; // Number of sets.

  cache_pkg::tag_entry_t  tags [`CACHE_WAYS][SETS]; // Tag, valid and LRU per line.
  cache_pkg::cache_addr_t addr_q;                   // Address of the request in flight.
  logic                   valid_q;                  // Stage is holding a request.
  cache_pkg::tag_entry_t  entry0;                   // Way 0 entry of the current set.
  cache_pkg::tag_entry_t  entry1;                   // Way 1 entry of the current set.
  logic                   match0;                   // Way 0 holds the requested line.
  logic                   match1;                   // Way 1 holds the requested line.

  //////////////////////////////
  // Request capture.
  //////////////////////////////
  // The fill controller only pulses done once cpu_req has fallen, so the
  // stage can accept the next request right after done.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;                      // Nothing in flight after reset.
    end else if (look.done) begin
      valid_q <= 1'b0;                      // Request completed on the processor side.
    end else if (!valid_q && cpu_req) begin
      valid_q <= 1'b1;                      // New request sampled while idle.
    end
  end

  always_ff @(posedge clk) begin
    if (!valid_q && cpu_req) begin
      addr_q <= cpu_addr;                   // Address is stable while cpu_req is high.
    end
  end

  //////////////////////////////
  // Tag compare.
  //////////////////////////////
  assign entry0 = tags[0][addr_q.index];
  assign entry1 = tags[1][addr_q.index];
  assign match0 = entry0.valid && (entry0.tag == addr_q.tag); // Way 0 hit.
  assign match1 = entry1.valid && (entry1.tag == addr_q.tag); // Way 1 hit.

  assign look.valid     = valid_q;
  assign look.addr      = addr_q;
  assign look.hit       = match0 || match1;  // Either way satisfies the request.
  assign look.hit_way   = match1;            // Way 0 unless way 1 matched.
  assign look.evict_way = !entry0.lru;       // Way 0 LRU bit picks the victim.

  // Word read from the data array, selected by set, word offset and hit way.
  assign rd_way  = match1;
  assign rd_addr = {addr_q.index, addr_q.offset[`CACHE_OFFSET_W-1:1]};

  //////////////////////////////
  // Tag and LRU updates.
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        for (int s = 0; s < SETS; s++) begin
          tags[w][s] <= '0;                 // All lines invalid, way 1 evicted first.
        end
      end
    end else begin
      if (look.tag_we) begin
        tags[look.evict_way][addr_q.index].tag   <= addr_q.tag; // New line's tag.
        tags[look.evict_way][addr_q.index].valid <= 1'b1;       // Line now usable.
      end
      if (look.lru_we) begin
        tags[look.lru_way][addr_q.index].lru  <= 1'b0; // Just used.
        tags[~look.lru_way][addr_q.index].lru <= 1'b1; // Other way goes next.
      end
    end
  end

  // The fill controller may only rewrite a tag for the request it is serving.
  a_tag_we_valid : assert property (@(posedge clk) disable iff (rst)
    look.tag_we |-> look.valid)
    else $error("tag_we without a request in the lookup stage");

endmodule

//--- hdl/cache_data_array.sv
// Data array: word storage for both ways, one write port and a registered read port.
`timescale 1ns/100ps
`include "cache_params.svh"

module cache_data_array (
  input  logic             clk,
  input  logic             we,
  input  logic             way,
  input  logic [`CACHE_INDEX_W+$clog2(`CACHE_LINE_WORDS)-1:0] waddr,
  input  cache_pkg::word_t wdata,
  input  logic             rd_way,
  input  logic [`CACHE_INDEX_W+$clog2(`CACHE_LINE_WORDS)-1:0] raddr,
  output cache_pkg::word_t rdata
);

  // Words per way times ways, 1024 in all.
  localparam int DEPTH = `CACHE_WAYS * (1 << `CACHE_INDEX_W) * `CACHE_LINE_WORDS;

  cache_pkg::word_t mem [DEPTH]; // Way bit on top, then set, then word.

  //////////////////////////////
  // Write port.
  //////////////////////////////
  // Filled one word at a time as memory returns the line.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[{way, waddr}] <= wdata;  // Word lands in the evicted way.
    end
  end

  //////////////////////////////
  // Read port.
  //////////////////////////////
  always_ff @(posedge clk) begin
    rdata <= mem[{rd_way, raddr}]; // One cycle read latency.
  end

endmodule

//--- hdl/cache_fill_ctrl.sv
// Fill controller: miss FSM, word counter, memory address register and both handshakes.
`timescale 1ns/100ps
`include "cache_params.svh"

module cache_fill_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  cache_lookup_if.fill             fill,
  input  logic                     cpu_req,
  output logic                     cpu_ack,
  output logic                     mem_req,
  output logic [`CACHE_ADDR_W-1:0] mem_addr,
  input  logic                     mem_ack,
  input  cache_pkg::word_t         mem_rdata,
  output logic                     data_we,
  output logic                     data_way,
  output logic [`CACHE_INDEX_W+$clog2(`CACHE_LINE_WORDS)-1:0] data_addr,
  output cache_pkg::word_t         data_wdata
);

  localparam int WORD_BITS = $clog2(`CACHE_LINE_WORDS);       // Word select within a line.
  localparam int STEP      = $bits(cache_pkg::word_t) / 8;    // Bytes per word.

  typedef enum logic [2:0] {
    IDLE, ISSUE, WAIT_ACK, WAIT_DROP, WRITE_TAG, RESPOND, RELEASE
  } fill_state_t;

  fill_state_t          state;  // Current FSM state.
  logic [WORD_BITS:0]   cnt;    // Words fetched so far, 0 to 8.
  logic                 miss_q; // Current request went through a line fill.
  logic                 start_fill; // Request just found to miss.

  assign start_fill = (state == IDLE) && fill.valid && !fill.hit;

  //////////////////////////////
  // Miss FSM.
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      cnt     <= '0;
      miss_q  <= 1'b0;
      cpu_ack <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (fill.valid) begin
            miss_q <= !fill.hit;                        // Remember which path was taken.
            cnt    <= '0;                               // Fill starts at word 0.
            state  <= fill.hit ? RESPOND : ISSUE;
          end
        end
        ISSUE: state <= WAIT_ACK;                       // Request is up, now wait.
        WAIT_ACK: begin
          if (mem_ack) begin
            cnt   <= cnt + 1'b1;                        // Word captured this cycle.
            state <= WAIT_DROP;
          end
        end
        WAIT_DROP: begin
          if (!mem_ack) begin                           // Four-phase cycle closed.
            state <= (cnt == (WORD_BITS+1)'(`CACHE_LINE_WORDS)) ? WRITE_TAG : ISSUE;
          end
        end
        WRITE_TAG: state <= RESPOND;                    // Tag lands, read follows.
        RESPOND: begin
          if (!cpu_ack) begin
            cpu_ack <= 1'b1;                            // Read data is valid now.
          end else if (!cpu_req) begin
            cpu_ack <= 1'b0;                            // Processor saw the word.
            state   <= RELEASE;
          end
        end
        RELEASE: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Memory side.
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (start_fill) begin
      mem_addr <= {fill.addr.tag, fill.addr.index, {`CACHE_OFFSET_W{1'b0}}}; // Line base.
    end else if (data_we) begin
      mem_addr <= mem_addr + `CACHE_ADDR_W'(STEP);      // Next word of the line.
    end
  end

  assign mem_req    = (state == ISSUE) || (state == WAIT_ACK);
  assign data_we    = (state == WAIT_ACK) && mem_ack;   // mem_rdata is valid with ack.
  assign data_way   = fill.evict_way;
  assign data_addr  = {fill.addr.index, cnt[WORD_BITS-1:0]};
  assign data_wdata = mem_rdata;

  //////////////////////////////
  // Lookup stage controls.
  //////////////////////////////
  assign fill.tag_we  = (state == WRITE_TAG);
  // Hit path updates LRU together with the rising cpu_ack.
  assign fill.lru_we  = (state == WRITE_TAG) || ((state == RESPOND) && !cpu_ack && !miss_q);
  assign fill.lru_way = fill.hit ? fill.hit_way : fill.evict_way;
  assign fill.done    = (state == RELEASE);

  // A new word request waits until the previous acknowledge has dropped.
  a_req_after_ack : assert property (@(posedge clk) disable iff (rst)
    $rose(mem_req) |-> !$past(mem_ack))
    else $error("mem_req rose while mem_ack was still high");

  a_cnt_range : assert property (@(posedge clk) disable iff (rst)
    cnt <= (WORD_BITS+1)'(`CACHE_LINE_WORDS))
    else $error("word counter ran past the end of the line");

endmodule

//--- hdl/cache_top.sv
// Cache top level: lookup stage, data array and fill controller with plain bus ports.
`timescale 1ns/100ps
`include "cache_params.svh"

module cache_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     cpu_req,
  input  logic [`CACHE_ADDR_W-1:0] cpu_addr,
  output logic                     cpu_ack,
  output logic [$bits(cache_pkg::word_t)-1:0] cpu_rdata,
  output logic                     mem_req,
  output logic [`CACHE_ADDR_W-1:0] mem_addr,
  input  logic                     mem_ack,
  input  logic [$bits(cache_pkg::word_t)-1:0] mem_rdata
);

  logic                   data_we;    // Fill write strobe.
  logic                   data_way;   // Way being filled.
  logic [`CACHE_INDEX_W+$clog2(`CACHE_LINE_WORDS)-1:0] data_addr; // Set and word to write.
  cache_pkg::word_t       data_wdata; // Word from memory.
  logic                   rd_way;     // Way to read.
  logic [`CACHE_INDEX_W+$clog2(`CACHE_LINE_WORDS)-1:0] rd_addr;   // Set and word to read.

  cache_lookup_if look_if ();         // Lookup stage to fill controller.

  cache_tag_lookup i_lookup (
    .clk      (clk),
    .rst      (rst),
    .cpu_req  (cpu_req),
    .cpu_addr (cpu_addr),
    .look     (look_if.lookup),
    .rd_way   (rd_way),
    .rd_addr  (rd_addr)
  );

  cache_data_array i_data (
    .clk    (clk),
    .we     (data_we),
    .way    (data_way),
    .waddr  (data_addr),
    .wdata  (data_wdata),
    .rd_way (rd_way),
    .raddr  (rd_addr),
    .rdata  (cpu_rdata)                // Processor reads straight from the array.
  );

  cache_fill_ctrl i_fill (
    .clk        (clk),
    .rst        (rst),
    .fill       (look_if.fill),
    .cpu_req    (cpu_req),
    .cpu_ack    (cpu_ack),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .data_we    (data_we),
    .data_way   (data_way),
    .data_addr  (data_addr),
    .data_wdata (data_wdata)
  );

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock and reset source: 4 ns clock and a reset held for three cycles.
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;    // 4 ns period.
  end

  initial begin
    rst = 1'b1;               // Reset is active from time zero.
    repeat (3) @(posedge clk);
    #0.5;
    rst = 1'b0;               // Released just after the third edge.
  end

endmodule

//--- verif/tb_ref.svh
// Testbench reference functions: memory word pattern, LFSR seed and LFSR step.

localparam logic [31:0] LFSR_SEED = 32'h7ecc4747; // Start state of every LFSR copy.

// Word stored at a byte address: rotate left by 5, then XOR a constant.
function automatic cache_pkg::word_t mem_word(input logic [15:0] byte_addr);
  return {byte_addr[10:0], byte_addr[15:11]} ^ 16'hA5C3;
endfunction

// Fibonacci LFSR with taps 32, 22, 2 and 1; the new bit enters at bit 0.
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

//--- verif/tb_mem_model.sv
// Memory responder: four-phase handshake, address-derived data, random ack delay, fill count.
`timescale 1ns/100ps
`include "cache_params.svh"

module tb_mem_model (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     mem_req,
  input  logic [`CACHE_ADDR_W-1:0] mem_addr,
  output logic                     mem_ack,
  output cache_pkg::word_t         mem_rdata,
  output int                       fill_count
);

  `include "tb_ref.svh"

  logic [31:0] lfsr;   // Private copy of the random source.
  logic [1:0]  delay;  // Wait states before this word's ack, 0 to 3.

  initial begin
    mem_ack    = 1'b0;
    mem_rdata  = '0;
    fill_count = 0;
    lfsr       = LFSR_SEED;
    forever begin
      @(posedge clk);
      if (!rst && mem_req) begin
        for (int i = 0; i < 2; i++) begin
          lfsr     = lfsr_step(lfsr);                   // One step per delay bit.
          delay[i] = lfsr[0];
        end
        repeat (delay) @(posedge clk);
        #0.5;
        mem_rdata = mem_word(mem_addr);                 // Data valid together with ack.
        mem_ack   = 1'b1;
        if (mem_addr[`CACHE_OFFSET_W-1:0] == '0) begin
          fill_count++;                                 // Line base word opens a new fill.
        end
        do @(posedge clk); while (mem_req);             // Wait for the request to drop.
        #0.5;
        mem_ack = 1'b0;                                 // Closes the four-phase cycle.
      end
    end
  end

endmodule

//--- verif/cache_tb.sv
// Cache testbench: stimulus, reference cache model, result compare, timeout and summary.
`timescale 1ns/100ps
`include "cache_params.svh"

module cache_tb;

  `include "tb_ref.svh"

  localparam int NUM_ACCESSES   = 1 + `CACHE_LINE_WORDS + 6 + 300; // All directed and random.
  localparam int TIMEOUT_CYCLES = 400 * NUM_ACCESSES;  // Bound on the whole run.
  localparam int SETS           = 1 << `CACHE_INDEX_W;

  logic                     clk;
  logic                     rst;
  logic                     cpu_req;
  cache_pkg::cache_addr_t   cpu_addr;
  logic                     cpu_ack;
  cache_pkg::word_t         cpu_rdata;
  logic                     mem_req;
  logic [`CACHE_ADDR_W-1:0] mem_addr;
  logic                     mem_ack;
  cache_pkg::word_t         mem_rdata;
  int                       fill_count;        // Fills seen by the memory model.

  logic [31:0]              lfsr = LFSR_SEED;  // Random address source.
  logic [`CACHE_TAG_W-1:0]  ref_tag [`CACHE_WAYS][SETS]; // Reference tags.
  logic                     ref_valid [`CACHE_WAYS][SETS];
  logic                     ref_mru [SETS];    // Most recently used way per set.
  logic [`CACHE_ADDR_W-1:0] cur_line = '0;     // Line base of the access in progress.
  int                       word_idx = 0;      // Memory words requested in this access.
  logic                     mem_req_seen = 1'b0;
  int                       cycles = 0;
  int                       mismatch_errs = 0;
  int                       proto_errs = 0;

  cache_pkg::cache_addr_t   acc_addr_q [$];    // Finished accesses, waiting for compare.
  cache_pkg::word_t         acc_data_q [$];
  int                       acc_fill_q [$];
  int                       acc_word_q [$];
  int                       acc_lat_q [$];

  tb_clk_gen i_clk (
    .clk (clk),
    .rst (rst)
  );

  tb_mem_model i_mem (
    .clk        (clk),
    .rst        (rst),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata),
    .fill_count (fill_count)
  );

  cache_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .cpu_req   (cpu_req),
    .cpu_addr  (cpu_addr),
    .cpu_ack   (cpu_ack),
    .cpu_rdata (cpu_rdata),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  //////////////////////////////
  // Reference model and checks.
  //////////////////////////////
  // Returns 1 when the access needs a line fill and updates tags and LRU.
  function automatic logic ref_lookup(input cache_pkg::cache_addr_t a);
    logic fill_needed;
    int   victim;
    fill_needed = 1'b1;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (ref_valid[w][a.index] && ref_tag[w][a.index] == a.tag) begin
        fill_needed     = 1'b0;           // Line present, just mark it used.
        ref_mru[a.index] = (w == 1);
      end
    end
    if (fill_needed) begin
      if (!ref_valid[0][a.index]) begin
        victim = 0;                       // Empty ways are used before any eviction.
      end else if (!ref_valid[1][a.index]) begin
        victim = 1;
      end else begin
        victim = ref_mru[a.index] ? 0 : 1; // Evict the least recently used way.
      end
      ref_tag[victim][a.index]   = a.tag;
      ref_valid[victim][a.index] = 1'b1;
      ref_mru[a.index]           = (victim == 1);
    end
    return fill_needed;
  endfunction

  task automatic check_word(input string name, input cache_pkg::word_t got,
                            input cache_pkg::word_t exp);
    if (got !== exp) begin
      mismatch_errs++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input cache_pkg::cache_addr_t got,
                            input cache_pkg::cache_addr_t exp);
    if (got !== exp) begin
      mismatch_errs++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      mismatch_errs++;
      $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
    end
  endtask

  // Memory words must walk the line from its base in steps of one word.
  always @(posedge clk) begin
    if (mem_req && !mem_req_seen) begin
      check_addr("mem_addr", mem_addr, cur_line + `CACHE_ADDR_W'(2 * word_idx));
      word_idx++;
    end
    mem_req_seen = mem_req;
  end

  always @(posedge clk) begin : compare_results
    cache_pkg::cache_addr_t a;
    logic                   fill_exp;
    int                     lat;
    while (acc_addr_q.size() > 0) begin
      a        = acc_addr_q.pop_front();
      fill_exp = ref_lookup(a);
      lat      = acc_lat_q.pop_front();
      check_word("cpu_rdata", acc_data_q.pop_front(), mem_word({a[15:1], 1'b0}));
      check_count("fill_count", acc_fill_q.pop_front(), int'(fill_exp));
      check_count("mem_req words", acc_word_q.pop_front(), fill_exp ? `CACHE_LINE_WORDS : 0);
      if (!fill_exp) begin
        check_count("cpu_ack hit delay", lat, 2); // Counted from the sampling edge.
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus.
  //////////////////////////////
  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);             // One step for every bit taken.
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  // One full four-phase access; called right after a rising edge.
  task automatic run_access(input cache_pkg::cache_addr_t addr, input int hold);
    int               start_fills;
    int               edges;
    cache_pkg::word_t got;
    #0.5;
    cur_line    = {addr.tag, addr.index, {`CACHE_OFFSET_W{1'b0}}};
    word_idx    = 0;
    start_fills = fill_count;
    edges       = 0;
    cpu_addr    = addr;
    cpu_req     = 1'b1;
    do begin
      @(posedge clk);
      edges++;                            // First edge is the one that samples cpu_req.
    end while (!cpu_ack);
    got = cpu_rdata;
    repeat (hold) begin
      @(posedge clk);
      if (!cpu_ack) begin
        proto_errs++;
        $display("cpu_ack dropped while cpu_req was still high");
      end
    end
    #0.5;
    cpu_req = 1'b0;
    @(posedge clk);
    @(posedge clk);                       // Ack must be low one cycle after req fell.
    if (cpu_ack) begin
      proto_errs++;
      $display("cpu_ack stayed high more than one cycle after cpu_req fell");
      while (cpu_ack) @(posedge clk);
    end
    acc_addr_q.push_back(addr);
    acc_data_q.push_back(got);
    acc_fill_q.push_back(fill_count - start_fills);
    acc_word_q.push_back(word_idx);
    acc_lat_q.push_back(edges - 2);       // Ack is seen one edge after it rises.
  endtask

  initial begin
    cache_pkg::cache_addr_t a;
    logic [15:0]            bits;
    cpu_req  = 1'b0;
    cpu_addr = '0;
    for (int s = 0; s < SETS; s++) begin
      ref_valid[0][s] = 1'b0;
      ref_valid[1][s] = 1'b0;
      ref_mru[s]      = 1'b0;
    end
    @(negedge rst);
    @(posedge clk);
    repeat (8) begin
      @(posedge clk);
      if (cpu_ack || mem_req) begin
        proto_errs++;
        $display("Handshake activity after reset with no request pending");
      end
    end
    run_access({6'h05, 6'h09, 4'h6}, 0);  // Cold miss.
    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
      run_access({6'h05, 6'h09, 4'(2 * w)}, 0); // Every word of the line now hits.
    end
    run_access({6'h01, 6'h15, 4'h0}, 0);  // A misses.
    run_access({6'h02, 6'h15, 4'h2}, 0);  // B misses into the other way.
    run_access({6'h01, 6'h15, 4'h4}, 0);  // A hits and becomes most recent.
    run_access({6'h03, 6'h15, 4'h6}, 0);  // C evicts B.
    run_access({6'h01, 6'h15, 4'h8}, 0);  // A still hits.
    run_access({6'h02, 6'h15, 4'hA}, 0);  // B misses again.
    repeat (300) begin
      take_bits(2, bits);
      a.tag = `CACHE_TAG_W'(bits);        // Four tags compete for two ways.
      take_bits(2, bits);
      a.index = `CACHE_INDEX_W'(bits);
      take_bits(3, bits);
      a.offset = {bits[2:0], 1'b0};
      take_bits(1, bits);
      run_access(a, 2 * bits);            // Sometimes hold cpu_req past the ack.
    end
    repeat (4) @(posedge clk);
    $display("Errors: %0d mismatches, %0d handshake failures", mismatch_errs, proto_errs);
    if (mismatch_errs + proto_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- cache_top.f
+incdir+hdl
+incdir+verif
hdl/cache_pkg.sv
hdl/cache_lookup_if.sv
hdl/cache_tag_lookup.sv
hdl/cache_data_array.sv
hdl/cache_fill_ctrl.sv
hdl/cache_top.sv
verif/tb_clk_gen.sv
verif/tb_mem_model.sv
verif/cache_tb.sv
